//--- ciDecoder.sv
`timescale 1ns/10ps

module ciDecoder #(
    parameter logic [7:0] customId = 8'h00
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            start,
    input  ramDmaPkg::wordT valueA,   // address, write flag, map select
    input  ramDmaPkg::wordT valueB,   // write data
    input  logic [7:0]      ciN,
    output logic            done,
    output ramDmaPkg::wordT result,
    sramPortIf.client       cpuSram,
    regAccessIf.master      regs
);
    logic              accept;     // instruction is ours and in range
    logic              isWrite;
    ramDmaPkg::regSelT mapSel;
    logic              sramRead;   // pending result comes from SRAM
    ramDmaPkg::wordT   heldValue;  // captured register value

    assign accept  = start && (ciN == customId) && (valueA[31:13] == '0);
    assign isWrite = valueA[9];
    assign mapSel  = ramDmaPkg::regSelT'(valueA[12:10]);

    // cpu port of the SRAM, address sampled at the end of the start cycle
    assign cpuSram.writeEnable = accept && isWrite && (mapSel == ramDmaPkg::mapSram);
    assign cpuSram.address     = valueA[8:0];
    assign cpuSram.writeData   = valueB;

    // register side, SRAM select excluded from writes
    assign regs.select      = mapSel;
    assign regs.writeStrobe = accept && isWrite && (mapSel != ramDmaPkg::mapSram);
    assign regs.writeData   = valueB;

    always_ff @(posedge clock) begin
        if (reset) begin
            done     <= 1'b0;
            sramRead <= 1'b0;
        end else begin
            done     <= accept;  // every accepted instruction, one cycle later
            sramRead <= accept && !isWrite && (mapSel == ramDmaPkg::mapSram);
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            heldValue <= isWrite ? '0 : regs.readData;  // writes answer zero
        end
    end

    // SRAM data arrives in the done cycle, so it bypasses the capture
    always_comb begin
        if (!done) begin
            result = '0;
        end else if (sramRead) begin
            result = cpuSram.readData;
        end else begin
            result = heldValue;
        end
    end

endmodule

//--- compile.f
ramDmaPkg.sv
ramDmaIfc.sv
dualPortSram.sv
ciDecoder.sv
dmaRegisters.sv
dmaEngine.sv
ramDmaTop.sv
tbBusSlave.sv
ramDmaTb.sv

//--- dmaEngine.sv
`timescale 1ns/10ps

module dmaEngine (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 grantedIn,
    input  ramDmaPkg::wordT      addressDataIn,     // incoming words
    input  logic                 endTransactionIn,
    input  logic                 dataValidIn,
    input  logic                 busErrorIn,
    input  logic                 busyIn,            // stalls word acceptance
    output logic                 requestOut,
    output ramDmaPkg::wordT      addressDataOut,
    output logic [3:0]           byteEnablesOut,
    output ramDmaPkg::burstSizeT burstSizeOut,
    output logic                 readNotWriteOut,
    output logic                 beginTransactionOut,
    sramPortIf.client            dmaSram,
    dmaConfigIf.engine           cfg
);
    ramDmaPkg::engineStateT state;
    ramDmaPkg::engineStateT nextState;
    ramDmaPkg::wordT        busAddr;       // running bus byte address
    ramDmaPkg::sramAddrT    sramAddr;      // running SRAM word address
    ramDmaPkg::blockSizeT   wordsLeft;     // block words still to come
    ramDmaPkg::blockSizeT   burstLeft;     // words still due in this burst
    ramDmaPkg::burstSizeT   burstSize;     // copy of the setting
    ramDmaPkg::blockSizeT   burstPlusOne;
    ramDmaPkg::blockSizeT   burstWords;    // length of the next burst
    logic                   wordAccept;

    // last burst may be shorter than the setting
    assign burstPlusOne = ramDmaPkg::blockSizeT'(burstSize) + ramDmaPkg::blockSizeT'(1);
    assign burstWords   = (burstPlusOne < wordsLeft) ? burstPlusOne : wordsLeft;
    assign wordAccept   = (state == ramDmaPkg::stateReceive) && dataValidIn && !busyIn
                          && (burstLeft != '0);

    always_comb begin
        nextState = state;
        if (state != ramDmaPkg::stateIdle && busErrorIn) begin
            nextState = ramDmaPkg::stateError;  // holds while the error line is high
        end else begin
            case (state)
                ramDmaPkg::stateIdle:    if (cfg.go) nextState = ramDmaPkg::stateRequest;
                ramDmaPkg::stateRequest: if (grantedIn) nextState = ramDmaPkg::stateGranted;
                ramDmaPkg::stateGranted: nextState = ramDmaPkg::stateReceive;
                ramDmaPkg::stateReceive: begin
                    if (endTransactionIn) nextState = ramDmaPkg::stateFinish;
                end
                ramDmaPkg::stateFinish: begin
                    nextState = (wordsLeft != '0) ? ramDmaPkg::stateRequest
                                                  : ramDmaPkg::stateIdle;
                end
                ramDmaPkg::stateError:   nextState = ramDmaPkg::stateIdle;
                default:                 nextState = ramDmaPkg::stateIdle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= ramDmaPkg::stateIdle;
            cfg.error <= 1'b0;
        end else begin
            state <= nextState;
            if (cfg.go) begin
                cfg.error <= 1'b0;  // fresh transfer clears the old error
            end else if (nextState == ramDmaPkg::stateError) begin
                cfg.error <= 1'b1;
            end
        end
    end

    // transfer counters and addresses
    always_ff @(posedge clock) begin
        if (state == ramDmaPkg::stateIdle && cfg.go) begin
            busAddr   <= cfg.busStart;
            sramAddr  <= cfg.sramStart;
            wordsLeft <= cfg.blockSize;
            burstSize <= cfg.burstSize;
            burstLeft <= '0;
        end else if (state == ramDmaPkg::stateGranted) begin
            burstLeft <= burstWords;
        end else if (wordAccept) begin
            busAddr   <= busAddr + ramDmaPkg::wordT'(ramDmaPkg::busAddrStep);
            sramAddr  <= sramAddr + ramDmaPkg::sramAddrT'(1);  // wraps at 512
            wordsLeft <= wordsLeft - ramDmaPkg::blockSizeT'(1);
            burstLeft <= burstLeft - ramDmaPkg::blockSizeT'(1);
        end
    end

    // words go straight into SRAM port 0
    assign dmaSram.writeEnable = wordAccept;
    assign dmaSram.address     = sramAddr;
    assign dmaSram.writeData   = addressDataIn;

    assign cfg.busy = (state != ramDmaPkg::stateIdle);

    // bus outputs decoded from the state
    assign requestOut          = (state == ramDmaPkg::stateRequest);
    assign beginTransactionOut = (state == ramDmaPkg::stateGranted);
    assign readNotWriteOut     = beginTransactionOut;  // only reads from the bus
    assign addressDataOut      = beginTransactionOut ? busAddr : '0;
    assign burstSizeOut        = beginTransactionOut
                                 ? ramDmaPkg::burstSizeT'(burstWords - ramDmaPkg::blockSizeT'(1))
                                 : '0;
    assign byteEnablesOut      = 4'hF;  // full words always

endmodule

//--- dmaRegisters.sv
`timescale 1ns/10ps

module dmaRegisters (
    input logic        clock,
    input logic        reset,
    regAccessIf.target regs,
    dmaConfigIf.source cfg
);
    logic transferActive;  // go issued or engine running
    logic settingWrite;
    logic controlWrite;

    assign transferActive = cfg.busy || cfg.go;
    assign settingWrite   = regs.writeStrobe && !transferActive;  // settings frozen
    assign controlWrite   = regs.writeStrobe
                            && (regs.select == ramDmaPkg::mapControlStatus)
                            && (regs.writeData == ramDmaPkg::wordT'(ramDmaPkg::controlFromBus));

    always_ff @(posedge clock) begin
        if (reset) begin
            cfg.busStart  <= '0;
            cfg.sramStart <= '0;
            cfg.blockSize <= '0;
            cfg.burstSize <= '0;
            cfg.go        <= 1'b0;
        end else begin
            // empty block or a running transfer starts nothing
            cfg.go <= controlWrite && (cfg.blockSize != '0) && !transferActive;
            if (settingWrite) begin
                case (regs.select)
                    ramDmaPkg::mapBusStart:  cfg.busStart  <= regs.writeData;
                    ramDmaPkg::mapSramStart: cfg.sramStart <= regs.writeData[8:0];
                    ramDmaPkg::mapBlockSize: cfg.blockSize <= regs.writeData[9:0];
                    ramDmaPkg::mapBurstSize: cfg.burstSize <= regs.writeData[7:0];
                    default: ;  // control handled above, other codes ignored
                endcase
            end
        end
    end

    // read-back, zero extended
    always_comb begin
        case (regs.select)
            ramDmaPkg::mapBusStart:      regs.readData = cfg.busStart;
            ramDmaPkg::mapSramStart:     regs.readData = {23'd0, cfg.sramStart};
            ramDmaPkg::mapBlockSize:     regs.readData = {22'd0, cfg.blockSize};
            ramDmaPkg::mapBurstSize:     regs.readData = {24'd0, cfg.burstSize};
            ramDmaPkg::mapControlStatus: regs.readData = {30'd0, cfg.error, transferActive};
            default:                     regs.readData = '0;
        endcase
    end

endmodule

//--- dualPortSram.sv
`timescale 1ns/10ps

module dualPortSram (
    input logic        clock,
    sramPortIf.memory  portA,  // dma side
    sramPortIf.memory  portB   // cpu side
);
    ramDmaPkg::wordT memory [ramDmaPkg::sramDepth];

    // both ports share one array, later write wins so port B takes a collision
    always_ff @(posedge clock) begin
        if (portA.writeEnable) begin
            memory[portA.address] <= portA.writeData;
        end
        if (portB.writeEnable) begin
            memory[portB.address] <= portB.writeData;
        end
    end

    // registered reads, old word on a same-cycle write
    always_ff @(posedge clock) begin
        portA.readData <= memory[portA.address];
        portB.readData <= memory[portB.address];
    end

endmodule

//--- ramDmaIfc.sv
`timescale 1ns/10ps

// one synchronous SRAM port, read data one cycle after the address
interface sramPortIf;
    logic                writeEnable;
    ramDmaPkg::sramAddrT address;
    ramDmaPkg::wordT     writeData;
    ramDmaPkg::wordT     readData;

    modport client (output writeEnable, address, writeData, input readData);
    modport memory (input writeEnable, address, writeData, output readData);
endinterface

interface dmaConfigIf;
    ramDmaPkg::wordT      busStart;
    ramDmaPkg::sramAddrT  sramStart;
    ramDmaPkg::blockSizeT blockSize;
    ramDmaPkg::burstSizeT burstSize;
    logic                 go;     // one-cycle start pulse
    logic                 busy;   // engine not idle
    logic                 error;  // sticky until next go

    modport source (output busStart, sramStart, blockSize, burstSize, go,
                    input busy, error);
    modport engine (input busStart, sramStart, blockSize, burstSize, go,
                    output busy, error);
endinterface

// combinational register access, the decoder captures readData
interface regAccessIf;
    ramDmaPkg::regSelT select;
    logic              writeStrobe;
    ramDmaPkg::wordT   writeData;
    ramDmaPkg::wordT   readData;

    modport master (output select, writeStrobe, writeData, input readData);
    modport target (input select, writeStrobe, writeData, output readData);
endinterface

//--- ramDmaPkg.sv
package ramDmaPkg;

    localparam int sramDepth      = 512;  // words in the shared SRAM
    localparam int busAddrStep    = 4;    // bytes per bus word
    localparam int controlFromBus = 1;    // control code for bus to SRAM copy

    typedef logic [31:0]                   wordT;       // data or bus word
    typedef logic [$clog2(sramDepth)-1:0]  sramAddrT;   // SRAM word address
    typedef logic [9:0]                    blockSizeT;  // block length in words
    typedef logic [7:0]                    burstSizeT;  // burst length minus one

    // register map, selected by valueA[12:10]
    typedef enum logic [2:0] {
        mapSram          = 3'd0,
        mapBusStart      = 3'd1,
        mapSramStart     = 3'd2,
        mapBlockSize     = 3'd3,
        mapBurstSize     = 3'd4,
        mapControlStatus = 3'd5   // control on write, status on read
    } regSelT;

    typedef enum logic [2:0] {
        stateIdle     = 3'd0,
        stateRequest  = 3'd1,  // bus requested, waiting for grant
        stateGranted  = 3'd2,  // begin pulse
        stateReceive  = 3'd3,  // words stream in
        stateFinish   = 3'd4,  // burst closed
        stateError    = 3'd5
    } engineStateT;

endpackage

//--- ramDmaTb.sv
`timescale 1ns/10ps

module ramDmaTb;
    localparam logic [7:0] customId = 8'h2A;
    localparam int maxVectors = 128;

    logic        clock;
    logic        reset;
    logic        start;
    logic [31:0] valueA;
    logic [31:0] valueB;
    logic [7:0]  ciN;
    logic        done;
    logic [31:0] result;
    logic        grantedIn, endTransactionIn, dataValidIn, busErrorIn, busyIn;
    logic [31:0] addressDataIn;
    logic        requestOut, readNotWriteOut, beginTransactionOut;
    logic [31:0] addressDataOut;
    logic [3:0]  byteEnablesOut;
    logic [7:0]  burstSizeOut;
    logic        armError;
    int          beginCount;
    logic [7:0]  lastBurstSize;

    logic [31:0] testNum [maxVectors];
    logic [31:0] opCode [maxVectors];
    logic [31:0] mapCol [maxVectors];
    logic [31:0] addrCol [maxVectors];
    logic [31:0] dataCol [maxVectors];
    int          vectorCount;
    logic        loaded;
    int          idx;
    int          errorCount, testErrors, testsRun, testsFailed, beginBase;
    logic [31:0] currentTest;

    ramDmaTop #(.customId(customId)) uut (.*);

    tbBusSlave busSlave (.*);

    always #20 clock = ~clock;

    task automatic reportFailure(input string msg);
        $display("test %0d: %s", currentTest, msg);
        errorCount++;
        testErrors++;
    endtask

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("error at %0t: test %0d %s, got %h expected %h",
                 $time, currentTest, what, got, expected);
        errorCount++;
        testErrors++;
    endtask

    task automatic loadVectors();
        int          fd;
        string       line;
        logic [31:0] t, o, m, a, d;
        fd = $fopen("ramDmaVectors.txt", "r");
        if (fd == 0) begin
            reportFailure("the vector file could not be opened");
        end else begin
            while (!$feof(fd) && vectorCount < maxVectors) begin
                // comment lines fail the scan and are skipped
                if ($fgets(line, fd) != 0
                    && $sscanf(line, "%h %h %h %h %h", t, o, m, a, d) == 5) begin
                    testNum[vectorCount] = t;
                    opCode[vectorCount] = o;
                    mapCol[vectorCount] = m;
                    addrCol[vectorCount] = a;
                    dataCol[vectorCount] = d;
                    vectorCount++;
                end
            end
            $fclose(fd);
        end
    endtask

    // one custom instruction with done one cycle after start
    task automatic issueInstruction(input logic [7:0] id, input logic [31:0] a,
                                    input logic [31:0] b, output logic gotDone,
                                    output logic [31:0] value);
        int waitCycles;
        @(negedge clock);
        start = 1'b1;
        valueA = a;
        valueB = b;
        ciN = id;
        @(negedge clock);
        start = 1'b0;
        gotDone = 1'b0;
        value = 32'd0;
        waitCycles = 0;
        while (!gotDone && waitCycles < 4) begin
            if (done) begin
                gotDone = 1'b1;
                value = result;
            end else begin
                waitCycles++;
                @(negedge clock);
            end
        end
        if (gotDone && waitCycles != 0) begin
            reportFailure("done came later than one cycle after start");
        end
    endtask

    task automatic runVector(input int i);
        logic        gotDone;
        logic [31:0] value;
        logic [31:0] a;
        int          polls;
        a = {19'd0, mapCol[i][2:0], 1'b0, addrCol[i][8:0]};
        case (opCode[i])
            32'd0: begin
                issueInstruction(customId, a | 32'h200, dataCol[i], gotDone, value);
                if (!gotDone) reportFailure("a write got no done");
                else if (value != 32'd0) reportMismatch("write result", value, 32'd0);
            end
            32'd1: begin
                issueInstruction(customId, a, 32'd0, gotDone, value);
                if (!gotDone) reportFailure("a read got no done");
                else if (value != dataCol[i])
                    reportMismatch($sformatf("read map %0d addr %h", mapCol[i], addrCol[i]),
                                   value, dataCol[i]);
            end
            32'd2: begin
                polls = 0;
                gotDone = 1'b1;
                value = 32'd1;
                while (gotDone && value[0] && polls < 500) begin
                    issueInstruction(customId, 32'h1400, 32'd0, gotDone, value);
                    polls++;
                end
                if (!gotDone) reportFailure("a status poll got no done");
                else if (value[0]) reportFailure("the engine stayed busy for too long");
            end
            32'd3: begin
                @(negedge clock);
                armError = 1'b1;  // slave sees it on the middle falling edge
                repeat (2) @(negedge clock);
                armError = 1'b0;
            end
            32'd4: begin
                issueInstruction(customId ^ 8'hFF, a | 32'h200, dataCol[i], gotDone, value);
                if (gotDone) reportFailure("an instruction with a wrong ciN got done");
            end
            32'd5: begin
                issueInstruction(customId, a | 32'h2200, dataCol[i], gotDone, value);
                if (gotDone) reportFailure("an out of range instruction got done");
            end
            32'd6: begin
                if (beginCount - beginBase != dataCol[i])
                    reportMismatch("begin count", 32'(beginCount - beginBase), dataCol[i]);
                beginBase = beginCount;
            end
            32'd7: begin
                if ({24'd0, lastBurstSize} != dataCol[i])
                    reportMismatch("last burst size", {24'd0, lastBurstSize}, dataCol[i]);
            end
            default: reportFailure("the vector file holds an unknown operation");
        endcase
    endtask

    task automatic finishTest();
        testsRun++;
        if (testErrors != 0) testsFailed++;
        $display("test %0d %s with %0d problems", currentTest,
                 (testErrors == 0) ? "passed" : "failed", testErrors);
        testErrors = 0;
    endtask

    // every burst is a bus read of full words
    always @(negedge clock) begin
        if (!reset && beginTransactionOut) begin
            if (!readNotWriteOut) begin
                reportMismatch("read flag at begin", {31'd0, readNotWriteOut}, 32'd1);
            end
            if (byteEnablesOut != 4'hF) begin
                reportMismatch("byte enables at begin", {28'd0, byteEnablesOut}, 32'hF);
            end
        end
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        valueA = 32'd0;
        valueB = 32'd0;
        ciN = 8'd0;
        armError = 1'b0;
        vectorCount = 0;
        errorCount = 0;
        testErrors = 0;
        testsRun = 0;
        testsFailed = 0;
        beginBase = 0;
        currentTest = 32'd0;
        loaded = 1'b0;
        loadVectors();
        loaded = 1'b1;
        repeat (5) @(negedge clock);
        reset = 1'b0;
        if (vectorCount > 0) currentTest = testNum[0];
        for (idx = 0; idx < vectorCount; idx++) begin
            if (testNum[idx] != currentTest) begin
                finishTest();
                currentTest = testNum[idx];
            end
            runVector(idx);
        end
        if (vectorCount > 0) finishTest();
        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
        if (errorCount == 0 && vectorCount > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // 2000 cycles per vector line
    initial begin
        wait (loaded);
        repeat (vectorCount * 2000 + 10) @(posedge clock);
        $display("watchdog ended the run after %0d cycles", vectorCount * 2000 + 10);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- ramDmaTop.sv
`timescale 1ns/10ps

module ramDmaTop #(
    parameter logic [7:0] customId = 8'h00
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start,
    input  ramDmaPkg::wordT      valueA,
    input  ramDmaPkg::wordT      valueB,
    input  logic [7:0]           ciN,
    output logic                 done,
    output ramDmaPkg::wordT      result,
    input  logic                 grantedIn,
    input  ramDmaPkg::wordT      addressDataIn,
    input  logic                 endTransactionIn,
    input  logic                 dataValidIn,
    input  logic                 busErrorIn,
    input  logic                 busyIn,
    output logic                 requestOut,
    output ramDmaPkg::wordT      addressDataOut,
    output logic [3:0]           byteEnablesOut,
    output ramDmaPkg::burstSizeT burstSizeOut,
    output logic                 readNotWriteOut,
    output logic                 beginTransactionOut
);
    sramPortIf  dmaPort ();  // SRAM port 0
    sramPortIf  cpuPort ();  // SRAM port 1
    dmaConfigIf dmaCfg  ();
    regAccessIf regBus  ();

    ciDecoder #(.customId(customId)) decoder (
        .clock(clock), .reset(reset), .start(start),
        .valueA(valueA), .valueB(valueB), .ciN(ciN),
        .done(done), .result(result),
        .cpuSram(cpuPort), .regs(regBus)
    );

    dmaRegisters registers (
        .clock(clock), .reset(reset), .regs(regBus), .cfg(dmaCfg)
    );

    dmaEngine engine (
        .clock(clock), .reset(reset),
        .grantedIn(grantedIn), .addressDataIn(addressDataIn),
        .endTransactionIn(endTransactionIn), .dataValidIn(dataValidIn),
        .busErrorIn(busErrorIn), .busyIn(busyIn),
        .requestOut(requestOut), .addressDataOut(addressDataOut),
        .byteEnablesOut(byteEnablesOut), .burstSizeOut(burstSizeOut),
        .readNotWriteOut(readNotWriteOut), .beginTransactionOut(beginTransactionOut),
        .dmaSram(dmaPort), .cfg(dmaCfg)
    );

    dualPortSram sram (
        .clock(clock), .portA(dmaPort), .portB(cpuPort)
    );

endmodule

//--- ramDmaVectors.txt
# columns, all hex: test op map addr data
# op 0 write, 1 read, 2 wait idle, 3 arm error, 4 bad ciN, 5 bad range, 6 begins, 7 last burst
1 0 0 010 12345678
1 0 0 1ff cafef00d
1 4 0 010 deadbeef
1 5 0 010 deadbeef
1 1 0 010 12345678
1 1 0 1ff cafef00d
2 1 5 000 00000000
2 0 1 000 a5a5c3c3
2 0 2 000 fffffe05
2 0 3 000 00000bcd
2 0 4 000 12345678
2 1 1 000 a5a5c3c3
2 1 2 000 00000005
2 1 3 000 000003cd
2 1 4 000 00000078
3 0 1 000 00001000
3 0 2 000 00000020
3 0 3 000 00000010
3 0 4 000 00000003
3 0 5 000 00000001
3 2 0 000 00000000
3 6 0 000 00000004
3 7 0 000 00000003
3 1 5 000 00000000
3 1 0 020 5a5a1000
3 1 0 02f 5a5a103c
4 0 1 000 00002000
4 0 2 000 000001fc
4 0 3 000 0000000a
4 0 5 000 00000001
4 2 0 000 00000000
4 6 0 000 00000003
4 7 0 000 00000001
4 1 0 1fc 5a5a2000
4 1 0 000 5a5a2010
4 1 0 005 5a5a2024
5 0 1 000 00003000
5 0 2 000 00000100
5 0 3 000 00000010
5 0 5 000 00000001
5 1 5 000 00000001
5 0 5 000 00000001
5 1 5 000 00000001
5 2 0 000 00000000
5 6 0 000 00000004
5 1 0 100 5a5a3000
5 1 0 10f 5a5a303c
6 3 0 000 00000000
6 0 1 000 00004000
6 0 5 000 00000001
6 2 0 000 00000000
6 1 5 000 00000002
6 0 1 000 00005000
6 0 2 000 00000180
6 0 3 000 00000008
6 0 5 000 00000001
6 2 0 000 00000000
6 1 5 000 00000000
6 6 0 000 00000003
6 1 0 180 5a5a5000
6 1 0 187 5a5a501c

//--- run.sh
#!/bin/bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing -f compile.f --top-module ramDmaTb -o ramDmaSim \
    && ./obj_dir/ramDmaSim | tee /dev/stderr | grep -q "All tests passed" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

//--- tbBusSlave.sv
`timescale 1ns/10ps

module tbBusSlave (
    input  logic        clock,
    input  logic        reset,
    input  logic        requestOut,
    input  logic        beginTransactionOut,
    input  logic [31:0] addressDataOut,
    input  logic [7:0]  burstSizeOut,
    input  logic        armError,          // error on the next burst
    output logic        grantedIn,
    output logic [31:0] addressDataIn,
    output logic        endTransactionIn,
    output logic        dataValidIn,
    output logic        busErrorIn,
    output logic        busyIn,
    output int          beginCount,        // begin pulses seen
    output logic [7:0]  lastBurstSize
);
    localparam int idlePhase = 0;
    localparam int grantPhase = 1;
    localparam int beginPhase = 2;
    localparam int streamPhase = 3;
    localparam int errorPhase = 4;

    logic [31:0] lfsrState;
    logic [31:0] busAddr;       // address of the word on offer
    logic [1:0]  bits;
    logic        armed;
    int          phase;
    int          delay;
    int          remaining;     // words of the burst not yet taken

    // right-shift Galois form, taps 32 22 2 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    task automatic drawTwoBits(output logic [1:0] drawn);
        drawn = 2'b00;
        repeat (2) begin
            drawn = {drawn[0], lfsrState[0]};  // one step per bit
            lfsrState = nextLfsr(lfsrState);
        end
    endtask

    initial begin
        lfsrState = 32'h5187bea7;
        grantedIn = 1'b0;
        addressDataIn = 32'd0;
        endTransactionIn = 1'b0;
        dataValidIn = 1'b0;
        busErrorIn = 1'b0;
        busyIn = 1'b0;
        beginCount = 0;
        lastBurstSize = 8'd0;
        armed = 1'b0;
        phase = idlePhase;
    end

    // outputs change on the falling edge only
    always @(negedge clock) begin
        grantedIn = 1'b0;
        endTransactionIn = 1'b0;
        if (armError) begin
            armed = 1'b1;
        end
        if (reset) begin
            phase = idlePhase;
            dataValidIn = 1'b0;
            busErrorIn = 1'b0;
        end else begin
            case (phase)
                idlePhase: begin
                    if (requestOut) begin
                        drawTwoBits(bits);
                        delay = int'(bits);  // 0 to 3 cycles before grant
                        phase = grantPhase;
                    end
                end
                grantPhase: begin
                    if (delay == 0) begin
                        grantedIn = 1'b1;
                        phase = beginPhase;
                    end else begin
                        delay = delay - 1;
                    end
                end
                beginPhase: begin
                    if (beginTransactionOut) begin
                        busAddr = addressDataOut;
                        remaining = int'(burstSizeOut) + 1;
                        lastBurstSize = burstSizeOut;
                        beginCount = beginCount + 1;
                        delay = 3;  // error length
                        phase = armed ? errorPhase : streamPhase;
                        armed = 1'b0;
                    end
                end
                streamPhase: begin
                    if (dataValidIn && !busyIn) begin  // word taken at the last edge
                        busAddr = busAddr + 32'd4;
                        remaining = remaining - 1;
                    end
                    if (remaining == 0) begin
                        dataValidIn = 1'b0;
                        busyIn = 1'b0;
                        endTransactionIn = 1'b1;
                        phase = idlePhase;
                    end else begin
                        drawTwoBits(bits);
                        dataValidIn = 1'b1;
                        addressDataIn = busAddr ^ 32'h5A5A0000;
                        busyIn = (bits == 2'b11);  // one in four cycles
                    end
                end
                default: begin
                    busErrorIn = (delay != 0);
                    if (delay == 0) begin
                        phase = idlePhase;
                    end else begin
                        delay = delay - 1;
                    end
                end
            endcase
        end
    end

endmodule
